//--- Bender.yml
package:
  name: exec_pipe
  description: "RV64I decode and execute pipeline slice"

sources:
  # Design sources in compile order.
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/id_ex_if.sv
      - source/reg_file.sv
      - source/inst_decode.sv
      - source/id_ex_reg.sv
      - source/execute_unit.sv
      - source/exec_pipe_top.sv

  # Testbench and the bound checker.
  - target: test
    include_dirs:
      - source
    files:
      - verif/exec_pipe_checker.sv
      - verif/exec_pipe_tb.sv

//--- files.f
+incdir+source
source/core_pkg.sv
source/id_ex_if.sv
source/reg_file.sv
source/inst_decode.sv
source/id_ex_reg.sv
source/execute_unit.sv
source/exec_pipe_top.sv
verif/exec_pipe_checker.sv
verif/exec_pipe_tb.sv

//--- source/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ####################
// Core dimensions
// ####################

// Data path and pc width.
`define CORE_XLEN 64

// Architectural integer registers.
`define CORE_NREGS 32

// Bits needed to name one register.
`define CORE_RIDX_W 5

`endif

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    // Major opcodes handled by this slice.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,  // Bubble value.
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // Always is used by jal and jalr.
    typedef enum logic [2:0] {
        br_none   = 3'd0,
        br_eq     = 3'd1,
        br_ne     = 3'd2,
        br_lt     = 3'd3,
        br_ge     = 3'd4,
        br_ltu    = 3'd5,
        br_geu    = 3'd6,
        br_always = 3'd7
    } br_cond_e;

endpackage

`default_nettype wire

//--- source/exec_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module exec_pipe_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    inst_valid,
    input  wire logic [31:0]             inst,
    input  wire logic [`CORE_XLEN-1:0]   pc,
    input  wire logic                    hold,
    output logic                         wb_valid,
    output logic      [`CORE_RIDX_W-1:0] wb_rd,
    output logic      [`CORE_XLEN-1:0]   wb_data,
    output logic      [`CORE_XLEN-1:0]   wb_pc,
    output logic                         redirect,
    output logic      [`CORE_XLEN-1:0]   redirect_pc,
    output logic                         halted
);

    id_ex_if id_bus ();
    id_ex_if ex_bus ();

    logic [`CORE_RIDX_W-1:0] rs1, rs2;
    logic [`CORE_XLEN-1:0]   rs1_val, rs2_val, ex_data;
    logic                    in_valid;

    // The slot behind a taken branch is discarded.
    assign in_valid = inst_valid && !halted && !redirect;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (wb_valid),
        .wa      (wb_rd),
        .wd      (wb_data)
    );

    inst_decode u_inst_decode (
        .inst     (inst),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .ex_valid (ex_bus.valid),
        .ex_rd    (ex_bus.rd),
        .ex_data  (ex_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .in_valid (in_valid),
        .id_bus   (id_bus.source)
    );

    id_ex_reg u_id_ex_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (hold),
        .flush  (redirect),
        .id_bus (id_bus.sink),
        .ex_bus (ex_bus.source)
    );

    execute_unit u_execute_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (hold),
        .ex_bus      (ex_bus.sink),
        .ex_data     (ex_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_pc       (wb_pc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted)
    );

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module execute_unit (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    hold,
    id_ex_if.sink                        ex_bus,
    output logic      [`CORE_XLEN-1:0]   ex_data,
    output logic                         wb_valid,
    output logic      [`CORE_RIDX_W-1:0] wb_rd,
    output logic      [`CORE_XLEN-1:0]   wb_data,
    output logic      [`CORE_XLEN-1:0]   wb_pc,
    output logic                         redirect,
    output logic      [`CORE_XLEN-1:0]   redirect_pc,
    output logic                         halted
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0]   a, b, alu_res;
    logic [5:0]              shamt;
    logic                    taken, stop;
    logic                    res_valid, res_ebreak, halted_q;
    logic [`CORE_RIDX_W-1:0] res_rd;
    logic [`CORE_XLEN-1:0]   res_data, res_pc;

    assign a     = ex_bus.src_a;
    assign b     = ex_bus.src_b;
    assign shamt = b[5:0];

    // ####################
    // ALU and compare
    // ####################
    always_comb begin
        case (ex_bus.alu_op)
            alu_sub:    alu_res = a - b;
            alu_sll:    alu_res = a << shamt;
            alu_slt:    alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   alu_res = {{(`CORE_XLEN-1){1'b0}}, a < b};
            alu_xor:    alu_res = a ^ b;
            alu_srl:    alu_res = a >> shamt;
            alu_sra:    alu_res = $unsigned($signed(a) >>> shamt);
            alu_or:     alu_res = a | b;
            alu_and:    alu_res = a & b;
            alu_pass_b: alu_res = b;
            default:    alu_res = a + b;
        endcase
    end

    assign ex_data = ex_bus.is_link ? ex_bus.pc + `CORE_XLEN'd4 : alu_res;

    always_comb begin
        case (ex_bus.br_cond)
            br_eq:     taken = a == ex_bus.rs2_val;
            br_ne:     taken = a != ex_bus.rs2_val;
            br_lt:     taken = $signed(a) < $signed(ex_bus.rs2_val);
            br_ge:     taken = $signed(a) >= $signed(ex_bus.rs2_val);
            br_ltu:    taken = a < ex_bus.rs2_val;
            br_geu:    taken = a >= ex_bus.rs2_val;
            br_always: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // Nothing behind an ebreak may commit or redirect.
    assign stop = halted_q || res_ebreak;

    assign redirect    = ex_bus.valid && taken && !hold && !stop;
    assign redirect_pc = {ex_bus.target[`CORE_XLEN-1:1], 1'b0};

    // ####################
    // Result register
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid  <= 1'b0;
            res_ebreak <= 1'b0;
            halted_q   <= 1'b0;
        end else if (!hold) begin
            res_valid  <= ex_bus.valid && ex_bus.rf_we && !stop;
            res_ebreak <= ex_bus.valid && ex_bus.ebreak && !stop;
            halted_q   <= halted_q || res_ebreak;  // Sticky until reset.
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            res_rd   <= ex_bus.rd;
            res_data <= ex_data;
            res_pc   <= ex_bus.pc;
        end
    end

    assign wb_valid = res_valid && !hold;  // One commit per result.
    assign wb_rd    = res_rd;
    assign wb_data  = res_data;
    assign wb_pc    = res_pc;
    assign halted   = halted_q;

endmodule

`default_nettype wire

//--- source/id_ex_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

interface id_ex_if;
    import core_pkg::*;

    logic                    valid;
    logic [`CORE_XLEN-1:0]   pc;
    alu_op_e                 alu_op;
    logic [`CORE_XLEN-1:0]   src_a;
    logic [`CORE_XLEN-1:0]   src_b;
    logic [`CORE_XLEN-1:0]   rs2_val;  // Compare operand for branches.
    logic [`CORE_XLEN-1:0]   target;
    logic [`CORE_RIDX_W-1:0] rd;
    logic                    rf_we;
    br_cond_e                br_cond;
    logic                    is_link;  // Write pc + 4.
    logic                    ebreak;

    modport source (
        output valid, pc, alu_op, src_a, src_b, rs2_val, target,
        output rd, rf_we, br_cond, is_link, ebreak
    );

    modport sink (
        input valid, pc, alu_op, src_a, src_b, rs2_val, target,
        input rd, rf_we, br_cond, is_link, ebreak
    );

endinterface

`default_nettype wire

//--- source/id_ex_reg.sv
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic hold,
    input  wire logic flush,
    id_ex_if.sink     id_bus,
    id_ex_if.source   ex_bus
);
    import core_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_bus.valid   <= 1'b0;
            ex_bus.pc      <= '0;
            ex_bus.alu_op  <= alu_add;
            ex_bus.src_a   <= '0;
            ex_bus.src_b   <= '0;
            ex_bus.rs2_val <= '0;
            ex_bus.target  <= '0;
            ex_bus.rd      <= '0;
            ex_bus.rf_we   <= 1'b0;
            ex_bus.br_cond <= br_none;
            ex_bus.is_link <= 1'b0;
            ex_bus.ebreak  <= 1'b0;
        end else if (flush) begin  // Load a bubble.
            ex_bus.valid   <= 1'b0;
            ex_bus.pc      <= '0;
            ex_bus.alu_op  <= alu_add;
            ex_bus.src_a   <= '0;
            ex_bus.src_b   <= '0;
            ex_bus.rs2_val <= '0;
            ex_bus.target  <= '0;
            ex_bus.rd      <= '0;
            ex_bus.rf_we   <= 1'b0;
            ex_bus.br_cond <= br_none;
            ex_bus.is_link <= 1'b0;
            ex_bus.ebreak  <= 1'b0;
        end else if (!hold) begin
            ex_bus.valid   <= id_bus.valid;
            ex_bus.pc      <= id_bus.pc;
            ex_bus.alu_op  <= id_bus.alu_op;
            ex_bus.src_a   <= id_bus.src_a;
            ex_bus.src_b   <= id_bus.src_b;
            ex_bus.rs2_val <= id_bus.rs2_val;
            ex_bus.target  <= id_bus.target;
            ex_bus.rd      <= id_bus.rd;
            ex_bus.rf_we   <= id_bus.rf_we;
            ex_bus.br_cond <= id_bus.br_cond;
            ex_bus.is_link <= id_bus.is_link;
            ex_bus.ebreak  <= id_bus.ebreak;
        end
    end

endmodule

`default_nettype wire

//--- source/inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module inst_decode (
    input  wire logic [31:0]             inst,
    input  wire logic [`CORE_XLEN-1:0]   pc,
    output logic      [`CORE_RIDX_W-1:0] rs1,
    output logic      [`CORE_RIDX_W-1:0] rs2,
    input  wire logic [`CORE_XLEN-1:0]   rs1_val,
    input  wire logic [`CORE_XLEN-1:0]   rs2_val,
    input  wire logic                    ex_valid,
    input  wire logic [`CORE_RIDX_W-1:0] ex_rd,
    input  wire logic [`CORE_XLEN-1:0]   ex_data,
    input  wire logic                    wb_valid,
    input  wire logic [`CORE_RIDX_W-1:0] wb_rd,
    input  wire logic [`CORE_XLEN-1:0]   wb_data,
    input  wire logic                    in_valid,
    id_ex_if.source                      id_bus
);
    import core_pkg::*;

    opcode_e                 opcode;
    logic [2:0]              funct3;
    logic [`CORE_RIDX_W-1:0] rd;
    logic [`CORE_XLEN-1:0]   imm_i, imm_b, imm_u, imm_j;
    logic [`CORE_XLEN-1:0]   op_a, op_b;
    logic                    known, writes, use_pc, use_zero, use_rs2;
    alu_op_e                 alu_op;
    br_cond_e                br_cond;
    logic                    is_link, is_ebreak;
    logic [`CORE_XLEN-1:0]   imm, tgt_base, tgt_off;

    // ####################
    // Fields and immediates
    // ####################
    assign opcode = opcode_e'(inst[6:0]);
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_b = {{(`CORE_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_u = {{(`CORE_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`CORE_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    // Execute result first, then writeback, then the register file.
    function automatic logic [`CORE_XLEN-1:0] fwd(
        input logic [`CORE_RIDX_W-1:0] idx,
        input logic [`CORE_XLEN-1:0]   rf_val
    );
        if (idx == '0) return '0;
        if (ex_valid && ex_rd == idx) return ex_data;
        if (wb_valid && wb_rd == idx) return wb_data;
        return rf_val;
    endfunction

    always_comb begin
        op_a = fwd(rs1, rs1_val);
        op_b = fwd(rs2, rs2_val);
    end

    // ####################
    // Control decode
    // ####################
    always_comb begin
        known     = 1'b1;
        writes    = 1'b0;
        use_pc    = 1'b0;
        use_zero  = 1'b0;
        use_rs2   = 1'b0;
        alu_op    = alu_add;
        br_cond   = br_none;
        is_link   = 1'b0;
        is_ebreak = 1'b0;
        imm       = imm_i;
        tgt_base  = pc;
        tgt_off   = imm_b;
        case (opcode)
            opc_op, opc_op_imm: begin
                writes  = 1'b1;
                use_rs2 = (opcode == opc_op);
                case (funct3)
                    3'b000:  alu_op = (opcode == opc_op && inst[30]) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = inst[30] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            opc_lui: begin
                writes   = 1'b1;
                use_zero = 1'b1;
                imm      = imm_u;
                alu_op   = alu_pass_b;
            end
            opc_auipc: begin
                writes = 1'b1;
                use_pc = 1'b1;
                imm    = imm_u;
            end
            opc_jal, opc_jalr: begin
                writes  = 1'b1;
                is_link = 1'b1;
                br_cond = br_always;
                tgt_off = (opcode == opc_jal) ? imm_j : imm_i;
                if (opcode == opc_jalr) tgt_base = op_a;
            end
            opc_branch: begin
                case (funct3)
                    3'b000:  br_cond = br_eq;
                    3'b001:  br_cond = br_ne;
                    3'b100:  br_cond = br_lt;
                    3'b101:  br_cond = br_ge;
                    3'b110:  br_cond = br_ltu;
                    3'b111:  br_cond = br_geu;
                    default: known = 1'b0;
                endcase
            end
            opc_system: begin
                is_ebreak = (inst == 32'h0010_0073);
                known     = is_ebreak;  // Other system ops become bubbles.
            end
            default: known = 1'b0;
        endcase
    end

    assign id_bus.valid   = in_valid && known;
    assign id_bus.pc      = pc;
    assign id_bus.alu_op  = alu_op;
    assign id_bus.src_a   = use_zero ? '0 : (use_pc ? pc : op_a);
    assign id_bus.src_b   = use_rs2 ? op_b : imm;
    assign id_bus.rs2_val = op_b;
    assign id_bus.target  = tgt_base + tgt_off;
    assign id_bus.rf_we   = writes && rd != '0;  // Writes to x0 are dropped here.
    assign id_bus.rd      = id_bus.rf_we ? rd : '0;
    assign id_bus.br_cond = br_cond;
    assign id_bus.is_link = is_link;
    assign id_bus.ebreak  = is_ebreak;

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [`CORE_RIDX_W-1:0] rs1,
    input  wire logic [`CORE_RIDX_W-1:0] rs2,
    output logic      [`CORE_XLEN-1:0]   rs1_val,
    output logic      [`CORE_XLEN-1:0]   rs2_val,
    input  wire logic                    we,
    input  wire logic [`CORE_RIDX_W-1:0] wa,
    input  wire logic [`CORE_XLEN-1:0]   wd
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads as zero.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verif/exec_pipe_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module exec_pipe_checker (
    input wire logic                    clk,
    input wire logic                    rst_n,
    input wire logic                    hold,
    input wire logic                    wb_valid,
    input wire logic [`CORE_RIDX_W-1:0] wb_rd,
    input wire logic                    redirect,
    input wire logic                    halted
);

    // ####################
    // Pipeline rules
    // ####################
    quiet_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        hold |-> !wb_valid && !redirect)
        else $error("Commit or redirect while hold is high.");

    // Writes to x0 are dropped in decode.
    no_x0_commit: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != '0)
        else $error("Writeback to x0.");

    redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect)
        else $error("Redirect longer than one cycle.");

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)  // Only reset clears it.
        else $error("Halted flag dropped.");

endmodule

`default_nettype wire

//--- verif/exec_pipe_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module exec_pipe_tb;

    localparam int          WAIT_LIMIT = 200;
    localparam logic [63:0] PC_BASE    = 64'h1000;
    localparam logic [63:0] SIGN_BIT   = 64'h8000_0000_0000_0000;
    localparam logic [31:0] EBREAK     = 32'h0010_0073;

    // RV64I major opcodes.
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_OP_IMM = 7'h13;
    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_JAL    = 7'h6f;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_BRANCH = 7'h63;

    typedef struct packed {
        logic [4:0]  rd;
        logic [63:0] data;
        logic [63:0] pc;
    } commit_t;

    logic                    clk;
    logic                    rst_n;
    logic                    inst_valid;
    logic [31:0]             inst;
    logic [`CORE_XLEN-1:0]   pc;
    logic                    hold;
    logic                    wb_valid;
    logic [`CORE_RIDX_W-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]   wb_data;
    logic [`CORE_XLEN-1:0]   wb_pc;
    logic                    redirect;
    logic [`CORE_XLEN-1:0]   redirect_pc;
    logic                    halted;

    logic [31:0] prog_word [$];
    logic        prog_flush [$];  // Entry is discarded behind a taken branch.
    logic [63:0] xregs [32];
    commit_t     exp_commits [$];
    logic [63:0] exp_redirects [$];
    logic        model_halted;
    logic        last_redirect;
    logic        halted_seen;

    exec_pipe_top dut (.*);

    bind exec_pipe_top exec_pipe_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    // ####################
    // Encoders
    // ####################
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // ####################
    // Reference model
    // ####################
    task automatic model_step(input logic [31:0] w, input logic [63:0] p,
                              output logic taken);
        logic [63:0] a, b, r, imm_i, imm_u, tgt;
        logic [5:0]  sh;
        logic        wr;
        commit_t     c;
        a     = xregs[w[19:15]];
        b     = xregs[w[24:20]];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_u = {{32{w[31]}}, w[31:12], 12'h000};
        wr    = 1'b0;
        taken = 1'b0;
        r     = '0;
        tgt   = '0;
        case (w[6:0])
            OPC_OP, OPC_OP_IMM: begin
                if (w[6:0] == OPC_OP_IMM) b = imm_i;
                sh = b[5:0];
                wr = 1'b1;
                case (w[14:12])
                    3'd0: r = (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
                    3'd1: r = a << sh;
                    3'd2: r = {63'd0, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)};  // Signed by bias.
                    3'd3: r = {63'd0, a < b};
                    3'd4: r = a ^ b;
                    3'd5: begin
                        r = a >> sh;
                        if (w[30] && a[63]) r = r | ~(~64'd0 >> sh);  // Sign fill.
                    end
                    3'd6: r = a | b;
                    default: r = a & b;
                endcase
            end
            OPC_LUI: begin
                wr = 1'b1;
                r  = imm_u;
            end
            OPC_AUIPC: begin
                wr = 1'b1;
                r  = p + imm_u;
            end
            OPC_JAL, OPC_JALR: begin
                wr    = 1'b1;
                r     = p + 64'd4;
                taken = 1'b1;
                if (w[6:0] == OPC_JAL)
                    tgt = p + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                else
                    tgt = (a + imm_i) & ~64'd1;
            end
            OPC_BRANCH: begin
                tgt = p + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (w[14:12])
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
                    3'd5: taken = (a ^ SIGN_BIT) >= (b ^ SIGN_BIT);
                    3'd6: taken = a < b;
                    3'd7: taken = a >= b;
                    default: taken = 1'b0;
                endcase
            end
            default: begin
                if (w == EBREAK) model_halted = 1'b1;  // Anything else is a bubble.
            end
        endcase
        if (wr && w[11:7] != 5'd0) begin
            xregs[w[11:7]] = r;
            c.rd   = w[11:7];
            c.data = r;
            c.pc   = p;
            exp_commits.push_back(c);
        end
        if (taken) exp_redirects.push_back(tgt);
    endtask

    // ####################
    // Monitor
    // ####################
    task automatic compare_commit();
        commit_t e;
        assert (exp_commits.size() != 0)
            else abort_run("A result was written back that the model did not expect.");
        e = exp_commits.pop_front();
        assert (wb_rd == e.rd && wb_data == e.data && wb_pc == e.pc)
            else abort_run($sformatf("FAIL at %0t: x%0d = %h from pc %h, expected x%0d = %h",
                                     $time, wb_rd, wb_data, wb_pc, e.rd, e.data));
    endtask

    task automatic verify_redirect();
        logic [63:0] t;
        assert (exp_redirects.size() != 0)
            else abort_run("Redirect pulsed although the model took no branch.");
        t = exp_redirects.pop_front();
        assert (redirect_pc == t)
            else abort_run($sformatf("FAIL at %0t: redirect to %h, expected %h",
                                     $time, redirect_pc, t));
    endtask

    // Sampled mid-cycle, clear of the edge.
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(hold && (wb_valid || redirect)))
                else abort_run("A commit or a redirect showed up while hold was high.");
            assert (!(redirect && last_redirect))
                else abort_run("Redirect stayed high for more than one cycle.");
            assert (halted || !halted_seen)
                else abort_run("The halted flag dropped without a reset.");
            if (wb_valid) compare_commit();
            if (redirect) verify_redirect();
            last_redirect = redirect;
            halted_seen   = halted_seen || halted;
        end
    end

    task automatic drain_pipeline();
        int n;
        n = 0;
        while (exp_commits.size() != 0 || exp_redirects.size() != 0) begin
            assert (n < WAIT_LIMIT)
                else abort_run("Timed out waiting for the expected results.");
            @(posedge clk);
            n++;
        end
    endtask

    task automatic await_halt();
        int n;
        n = 0;
        while (!halted) begin
            assert (n < WAIT_LIMIT)
                else abort_run("Timed out waiting for the halted flag after ebreak.");
            @(posedge clk);
            n++;
        end
    endtask

    // ####################
    // Instruction table
    // ####################
    task automatic append_entry(input logic [31:0] w, input logic flushed);
        prog_word.push_back(w);
        prog_flush.push_back(flushed);
    endtask

    task automatic build_program();
        append_entry(i_type(OPC_OP_IMM, 3'd0, 1, 0, 100), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd0, 2, 0, -7), 1'b0);
        append_entry(r_type(7'h00, 3'd0, 3, 1, 2), 1'b0);      // Add, forwards from execute.
        append_entry(r_type(7'h20, 3'd0, 4, 3, 1), 1'b0);      // Sub, x1 from the file.
        append_entry(r_type(7'h00, 3'd1, 5, 1, 3), 1'b0);      // Sll, x3 from writeback.
        append_entry(r_type(7'h00, 3'd2, 6, 2, 1), 1'b0);
        append_entry(r_type(7'h00, 3'd3, 7, 2, 1), 1'b0);
        append_entry(r_type(7'h00, 3'd4, 8, 1, 2), 1'b0);
        append_entry(r_type(7'h00, 3'd5, 9, 2, 1), 1'b0);
        append_entry(r_type(7'h20, 3'd5, 10, 2, 1), 1'b0);
        append_entry(r_type(7'h00, 3'd6, 11, 1, 2), 1'b0);
        append_entry(r_type(7'h00, 3'd7, 12, 1, 2), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd2, 13, 2, -3), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd3, 14, 1, -1), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd4, 15, 2, 12'h555), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd6, 16, 1, -256), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd7, 17, 2, 12'h0f0), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd1, 18, 2, 33), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd5, 19, 2, 60), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd5, 20, 2, 12'h403), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd0, 0, 1, 5), 1'b0);  // Write to x0.
        append_entry(r_type(7'h00, 3'd0, 21, 0, 1), 1'b0);
        append_entry(u_type(OPC_LUI, 22, 20'h80001), 1'b0);
        append_entry(u_type(OPC_AUIPC, 23, 20'h12345), 1'b0);
        append_entry(b_type(3'd0, 1, 1, 8), 1'b0);              // Beq taken.
        append_entry(i_type(OPC_OP_IMM, 3'd0, 24, 0, 1), 1'b1);
        append_entry(b_type(3'd1, 1, 1, 8), 1'b0);
        append_entry(b_type(3'd4, 2, 1, 12), 1'b0);             // Blt taken.
        append_entry(i_type(OPC_OP_IMM, 3'd0, 24, 0, 2), 1'b1);
        append_entry(b_type(3'd5, 2, 1, 8), 1'b0);
        append_entry(b_type(3'd6, 2, 1, 8), 1'b0);
        append_entry(b_type(3'd7, 2, 1, 16), 1'b0);             // Bgeu taken.
        append_entry(i_type(OPC_OP_IMM, 3'd0, 24, 0, 3), 1'b1);
        append_entry(j_type(25, 64), 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd0, 24, 0, 4), 1'b1);
        append_entry(i_type(OPC_OP_IMM, 3'd0, 26, 25, 1), 1'b0);
        append_entry(i_type(OPC_JALR, 3'd0, 27, 26, 4), 1'b0);  // Odd target.
        append_entry(i_type(OPC_OP_IMM, 3'd0, 24, 0, 5), 1'b1);
        append_entry(r_type(7'h00, 3'd0, 28, 27, 26), 1'b0);
        append_entry(32'h0000_0000, 1'b0);                      // Unknown opcode.
        append_entry(EBREAK, 1'b0);
        append_entry(i_type(OPC_OP_IMM, 3'd0, 29, 0, 9), 1'b0);
        append_entry(b_type(3'd0, 0, 0, 8), 1'b0);
    endtask

    // ####################
    // Stimulus
    // ####################
    initial begin
        int   holds;
        logic taken;
        logic skip;
        void'($urandom(50));
        rst_n         = 1'b0;
        inst_valid    = 1'b0;
        inst          = '0;
        pc            = '0;
        hold          = 1'b0;
        model_halted  = 1'b0;
        last_redirect = 1'b0;
        halted_seen   = 1'b0;
        skip          = 1'b0;
        taken         = 1'b0;
        foreach (xregs[i]) begin
            xregs[i] = '0;
        end
        build_program();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < prog_word.size(); i++) begin
            holds = $urandom_range(0, 2);
            repeat (holds) begin
                hold = 1'b1;
                @(posedge clk);
                #1;
            end
            hold       = 1'b0;
            inst_valid = 1'b1;
            inst       = prog_word[i];
            pc         = PC_BASE + 64'(4 * i);
            if (!model_halted) begin
                assert (prog_flush[i] == skip)
                    else abort_run($sformatf("Table entry %0d has the wrong flush flag.", i));
                if (skip) begin
                    skip = 1'b0;
                end else begin
                    model_step(prog_word[i], pc, taken);
                    skip = taken;
                end
            end
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
        end

        drain_pipeline();
        if (model_halted) await_halt();
        repeat (10) @(posedge clk);  // Room for stray commits to show.
        assert (halted == model_halted) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("The halted flag does not match the model at the end of the run.");
        end
    end

endmodule

`default_nettype wire
